// ==== design/div_collect.sv ====
`timescale 1ns/10ps

module div_collect #(
    parameter int NUM_LANES = 4
) (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       res_ready_i,
    output logic                       res_valid_o,
    output logic [div_pkg::TAG_W-1:0]  res_tag_o,
    output logic [div_pkg::DATA_W-1:0] res_quotient_o,
    output logic [div_pkg::DATA_W-1:0] res_remainder_o,
    div_lane_if.collect                lanes [NUM_LANES-1:0]
);
    import div_pkg::*;

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [NUM_LANES-1:0] valid;
    logic [TAG_W-1:0]     tag_a [NUM_LANES];
    logic [DATA_W-1:0]    quo_a [NUM_LANES];
    logic [DATA_W-1:0]    rem_a [NUM_LANES];

    logic [PTR_W-1:0]     ptr_q;
    logic [PTR_W-1:0]     sel;
    logic                 found;
    logic                 load;

    // Flatten the lane results
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_res
        assign valid[i]           = lanes[i].res_valid;
        assign tag_a[i]           = lanes[i].res_tag;
        assign quo_a[i]           = lanes[i].res_quotient;
        assign rem_a[i]           = lanes[i].res_remainder;
        assign lanes[i].res_ready = load && (sel == PTR_W'(i));
    end

    // --------------------
    // Round-robin pick
    // --------------------

    // First valid lane at or after the pointer
    always_comb begin : p_pick
        int idx;
        found = 1'b0;
        sel   = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            idx = (int'(ptr_q) + k) % NUM_LANES;
            if (!found && valid[idx]) begin
                found = 1'b1;
                sel   = PTR_W'(idx);
            end
        end
    end

    // Output register empty or draining this cycle
    assign load = found && (!res_valid_o || res_ready_i);

    // --------------------
    // Output register
    // --------------------

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_valid_o <= 1'b0;
            ptr_q       <= '0;
        end else begin
            if (load) begin
                res_valid_o <= 1'b1;
                ptr_q       <= (sel == PTR_W'(NUM_LANES - 1)) ? '0 : sel + 1'b1;
            end else if (res_ready_i) begin
                res_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            res_tag_o       <= tag_a[sel];
            res_quotient_o  <= quo_a[sel];
            res_remainder_o <= rem_a[sel];
        end
    end

endmodule

// ==== design/div_dispatch.sv ====
`timescale 1ns/10ps

module div_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [7:0]                paddr_i,
    input  logic [div_pkg::DATA_W-1:0] pwdata_i,
    output logic [div_pkg::DATA_W-1:0] prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    div_lane_if.dispatch              lanes [NUM_LANES-1:0]
);
    import div_pkg::*;

    logic [DATA_W-1:0]    dividend_q;
    logic [DATA_W-1:0]    divisor_q;
    logic [TAG_W-1:0]     tag_q;
    logic                 pslverr_q;

    logic [NUM_LANES-1:0] free;
    logic [NUM_LANES-1:0] grant;
    logic                 access;
    logic                 addr_ok;
    logic                 ctrl_wr;
    logic                 issue;

    // --------------------
    // APB decode
    // --------------------

    assign access  = psel_i && penable_i;
    assign addr_ok = (paddr_i == ADDR_DIVIDEND) || (paddr_i == ADDR_DIVISOR) ||
                     (paddr_i == ADDR_CTRL) || (paddr_i == ADDR_STATUS);
    assign ctrl_wr = access && pwrite_i && (paddr_i == ADDR_CTRL);
    assign issue   = ctrl_wr && (|free);

    // CTRL writes wait for a free lane
    assign pready_o  = ctrl_wr ? (|free) : 1'b1;
    assign pslverr_o = pslverr_q;

    // Lowest set bit of the free map
    assign grant = free & (~free + 1'b1);

    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            ADDR_DIVIDEND: prdata_o = dividend_q;
            ADDR_DIVISOR:  prdata_o = divisor_q;
            ADDR_STATUS: begin
                prdata_o[NUM_LANES-1:0] = free;
                prdata_o[15:8]          = 8'(tag_q);
            end
            default: prdata_o = '0;
        endcase
    end

    // --------------------
    // Registers
    // --------------------

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dividend_q <= '0;
            divisor_q  <= '0;
            tag_q      <= '0;
            pslverr_q  <= 1'b0;
        end else begin
            // Error flag set in setup so it lines up with the access cycle
            pslverr_q <= psel_i && !penable_i && !addr_ok;
            if (access && pwrite_i && (paddr_i == ADDR_DIVIDEND)) begin
                dividend_q <= pwdata_i;
            end
            if (access && pwrite_i && (paddr_i == ADDR_DIVISOR)) begin
                divisor_q <= pwdata_i;
            end
            if (issue) begin
                tag_q <= tag_q + 1'b1;
            end
        end
    end

    // --------------------
    // Lane requests
    // --------------------

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_req
        assign free[i]               = lanes[i].req_ready;
        assign lanes[i].req_valid    = issue && grant[i];
        assign lanes[i].req_op       = div_op_e'(pwdata_i[0]);
        assign lanes[i].req_tag      = tag_q;
        assign lanes[i].req_dividend = dividend_q;
        assign lanes[i].req_divisor  = divisor_q;
    end

endmodule

// ==== design/div_lane.sv ====
`timescale 1ns/10ps

module div_lane (
    input  logic     clk,
    input  logic     arst_n_i,
    div_lane_if.lane lane
);
    import div_pkg::*;

    localparam int CNT_W = $clog2(DATA_W);

    lane_state_e       state_q;
    logic [CNT_W-1:0]  cnt_q;

    logic [DATA_W-1:0] rem_q;
    logic [DATA_W-1:0] quo_q;
    logic [DATA_W-1:0] dsr_q;
    logic              q_neg_q;
    logic              r_neg_q;
    logic              dsr_zero_q;
    logic [TAG_W-1:0]  tag_q;

    logic              accept;
    logic              res_xfer;
    logic              is_signed;
    logic              a_neg;
    logic              b_neg;
    logic [DATA_W-1:0] a_abs;
    logic [DATA_W-1:0] b_abs;
    logic [DATA_W:0]   shifted;
    logic [DATA_W:0]   diff;

    assign accept   = lane.req_valid && lane.req_ready;
    assign res_xfer = lane.res_valid && lane.res_ready;

    // --------------------
    // Operand conditioning
    // --------------------

    assign is_signed = (lane.req_op == OP_DIV);
    assign a_neg     = is_signed && lane.req_dividend[DATA_W-1];
    assign b_neg     = is_signed && lane.req_divisor[DATA_W-1];
    assign a_abs     = ({DATA_W{a_neg}} ^ lane.req_dividend) + DATA_W'(a_neg);
    assign b_abs     = ({DATA_W{b_neg}} ^ lane.req_divisor) + DATA_W'(b_neg);

    // Trial subtraction, top bit is the borrow
    assign shifted = {rem_q, quo_q[DATA_W-1]};
    assign diff    = shifted - {1'b0, dsr_q};

    // --------------------
    // FSM
    // --------------------

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= LANE_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                LANE_IDLE: begin
                    if (accept) begin
                        state_q <= LANE_ITER;
                        cnt_q   <= '0;
                    end
                end
                LANE_ITER: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(DATA_W - 1)) begin
                        state_q <= LANE_FIX;
                    end
                end
                LANE_FIX:  state_q <= LANE_DONE;
                LANE_DONE: begin
                    if (res_xfer) begin
                        state_q <= LANE_IDLE;
                    end
                end
                default:   state_q <= LANE_IDLE;
            endcase
        end
    end

    // --------------------
    // Datapath
    // --------------------

    always_ff @(posedge clk) begin
        case (state_q)
            LANE_IDLE: begin
                if (accept) begin
                    rem_q      <= '0;
                    quo_q      <= a_abs;
                    dsr_q      <= b_abs;
                    q_neg_q    <= is_signed &&
                                  (lane.req_dividend[DATA_W-1] ^ lane.req_divisor[DATA_W-1]);
                    r_neg_q    <= a_neg;
                    dsr_zero_q <= (lane.req_divisor == '0);
                    tag_q      <= lane.req_tag;
                end
            end
            LANE_ITER: begin
                // Dividend bits shift out the top while quotient bits enter below
                rem_q <= diff[DATA_W] ? shifted[DATA_W-1:0] : diff[DATA_W-1:0];
                quo_q <= {quo_q[DATA_W-2:0], !diff[DATA_W]};
            end
            LANE_FIX: begin
                if (dsr_zero_q) begin
                    quo_q <= '1;
                end else if (q_neg_q) begin
                    quo_q <= ~quo_q + 1'b1;
                end
                // Remainder sign follows the dividend
                if (r_neg_q) begin
                    rem_q <= ~rem_q + 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    assign lane.req_ready     = (state_q == LANE_IDLE);
    assign lane.res_valid     = (state_q == LANE_DONE);
    assign lane.res_tag       = tag_q;
    assign lane.res_quotient  = quo_q;
    assign lane.res_remainder = rem_q;

endmodule

// ==== design/div_lane_if.sv ====
`timescale 1ns/10ps

interface div_lane_if;
    import div_pkg::*;

    // Request side
    logic              req_valid;
    logic              req_ready;
    div_op_e           req_op;
    logic [TAG_W-1:0]  req_tag;
    logic [DATA_W-1:0] req_dividend;
    logic [DATA_W-1:0] req_divisor;

    // Result side
    logic              res_valid;
    logic              res_ready;
    logic [TAG_W-1:0]  res_tag;
    logic [DATA_W-1:0] res_quotient;
    logic [DATA_W-1:0] res_remainder;

    modport dispatch (
        output req_valid, req_op, req_tag, req_dividend, req_divisor,
        input  req_ready
    );

    modport lane (
        input  req_valid, req_op, req_tag, req_dividend, req_divisor,
        output req_ready,
        output res_valid, res_tag, res_quotient, res_remainder,
        input  res_ready
    );

    modport collect (
        input  res_valid, res_tag, res_quotient, res_remainder,
        output res_ready
    );

endinterface

// ==== design/div_pkg.sv ====
package div_pkg;

    // --------------------
    // Widths
    // --------------------

    // Operand and APB data width
    localparam int DATA_W = 32;

    // Operation tag, wraps at 16
    localparam int TAG_W = 4;

    // --------------------
    // Enums
    // --------------------

    // Opcode taken from CTRL write data bit 0
    typedef enum logic {
        OP_DIVU = 1'b0,
        OP_DIV  = 1'b1
    } div_op_e;

    // Lane FSM
    typedef enum logic [1:0] {
        LANE_IDLE = 2'd0,
        LANE_ITER = 2'd1,
        LANE_FIX  = 2'd2,
        LANE_DONE = 2'd3
    } lane_state_e;

    // --------------------
    // APB register map
    // --------------------

    // Byte offsets
    localparam logic [7:0] ADDR_DIVIDEND = 8'h00;
    localparam logic [7:0] ADDR_DIVISOR  = 8'h04;
    localparam logic [7:0] ADDR_CTRL     = 8'h08;
    localparam logic [7:0] ADDR_STATUS   = 8'h0C;

endpackage

// ==== design/div_unit_top.sv ====
`timescale 1ns/10ps

module div_unit_top #(
    parameter int NUM_LANES = 4
) (
    input  logic                       clk,
    input  logic                       arst_n_i,

    // APB slave
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [7:0]                 paddr_i,
    input  logic [div_pkg::DATA_W-1:0] pwdata_i,
    output logic [div_pkg::DATA_W-1:0] prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,

    // Result stream
    input  logic                       res_ready_i,
    output logic                       res_valid_o,
    output logic [div_pkg::TAG_W-1:0]  res_tag_o,
    output logic [div_pkg::DATA_W-1:0] res_quotient_o,
    output logic [div_pkg::DATA_W-1:0] res_remainder_o
);

    div_lane_if lane_if [NUM_LANES-1:0] ();

    div_dispatch #(
        .NUM_LANES (NUM_LANES)
    ) u_dispatch (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .lanes     (lane_if)
    );

    // One divider per lane
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        div_lane u_lane (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .lane     (lane_if[i])
        );
    end

    div_collect #(
        .NUM_LANES (NUM_LANES)
    ) u_collect (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .res_ready_i     (res_ready_i),
        .res_valid_o     (res_valid_o),
        .res_tag_o       (res_tag_o),
        .res_quotient_o  (res_quotient_o),
        .res_remainder_o (res_remainder_o),
        .lanes           (lane_if)
    );

endmodule

// ==== div_unit_top.f ====
design/div_pkg.sv
design/div_lane_if.sv
design/div_dispatch.sv
design/div_lane.sv
design/div_collect.sv
design/div_unit_top.sv
dv/div_unit_properties.sv
dv/div_unit_tb.sv

// ==== dv/div_unit_properties.sv ====
`timescale 1ns/10ps

module div_unit_properties (
    input logic                       clk,
    input logic                       arst_n_i,
    input logic                       psel_i,
    input logic                       penable_i,
    input logic                       pwrite_i,
    input logic [div_pkg::DATA_W-1:0] prdata_i,
    input logic                       pready_i,
    input logic                       pslverr_i,
    input logic                       res_ready_i,
    input logic                       res_valid_i,
    input logic [div_pkg::TAG_W-1:0]  res_tag_i,
    input logic [div_pkg::DATA_W-1:0] res_quotient_i,
    input logic [div_pkg::DATA_W-1:0] res_remainder_i
);

    // Stalled result keeps valid and its data
    a_res_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_tag_i) &&
            $stable(res_quotient_i) && $stable(res_remainder_i))
        else $error("Result stream changed before it was accepted");

    a_err_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
        pslverr_i |-> pready_i)
        else $error("PSLVERR high while PREADY low");

    // Read data known when a read completes
    a_rdata_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        psel_i && penable_i && !pwrite_i && pready_i |-> !$isunknown(prdata_i))
        else $error("Unknown read data on a completed APB read");

endmodule

bind div_unit_top div_unit_properties u_props (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .pwrite_i        (pwrite_i),
    .prdata_i        (prdata_o),
    .pready_i        (pready_o),
    .pslverr_i       (pslverr_o),
    .res_ready_i     (res_ready_i),
    .res_valid_i     (res_valid_o),
    .res_tag_i       (res_tag_o),
    .res_quotient_i  (res_quotient_o),
    .res_remainder_i (res_remainder_o)
);

// ==== dv/div_unit_tb.sv ====
`timescale 1ns/10ps

module div_unit_tb;
    import div_pkg::*;

    localparam int NUM_LANES = 4;
    // Register test, unsigned, signed, corners, back-pressure
    localparam int NUM_OPS   = 1 + 20 + 14 + 8 + NUM_LANES + 2;
    localparam int MAX_CYCLES = 40 * NUM_OPS + 500;

    logic              clk;
    logic              arst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [7:0]        paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              res_ready;
    logic              res_valid;
    logic [TAG_W-1:0]  res_tag;
    logic [DATA_W-1:0] res_quotient;
    logic [DATA_W-1:0] res_remainder;

    // Scoreboard indexed by tag
    logic [DATA_W-1:0] exp_q [1 << TAG_W];
    logic [DATA_W-1:0] exp_r [1 << TAG_W];
    logic              pending [1 << TAG_W];
    logic [TAG_W-1:0]  next_tag;
    logic [DATA_W-1:0] sh_a;
    logic [DATA_W-1:0] sh_b;
    int                issued;
    int                received;
    int                mismatches;
    int                other_errs;
    int                cycles;

    div_unit_top #(
        .NUM_LANES (NUM_LANES)
    ) uut (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .psel_i          (psel),
        .penable_i       (penable),
        .pwrite_i        (pwrite),
        .paddr_i         (paddr),
        .pwdata_i        (pwdata),
        .prdata_o        (prdata),
        .pready_o        (pready),
        .pslverr_o       (pslverr),
        .res_ready_i     (res_ready),
        .res_valid_o     (res_valid),
        .res_tag_o       (res_tag),
        .res_quotient_o  (res_quotient),
        .res_remainder_o (res_remainder)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------
    // Reference model and checks
    // --------------------

    // Quotient truncates toward zero, remainder takes the dividend's sign
    function automatic void model_div(input logic sgn, input logic [DATA_W-1:0] a,
                                      input logic [DATA_W-1:0] b,
                                      output logic [DATA_W-1:0] q,
                                      output logic [DATA_W-1:0] r);
        longint sa;
        longint sb;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (sgn) begin
            q = DATA_W'(sa / sb);
            r = DATA_W'(sa % sb);
        end else begin
            q = a / b;
            r = a % b;
        end
    endfunction

    task automatic check_equal(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got 0x%h, expected 0x%h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    // --------------------
    // APB tasks
    // --------------------

    task automatic apb_xfer(input logic wr, input logic [7:0] addr,
                            input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        // Sample mid-cycle, the transfer ends on the next edge
        @(negedge clk);
        while (!pready) @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [DATA_W-1:0] data,
                             input logic exp_err);
        logic [DATA_W-1:0] rdata;
        logic              err;
        apb_xfer(1'b1, addr, data, rdata, err);
        check_equal("pslverr_o", DATA_W'(err), DATA_W'(exp_err));
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [DATA_W-1:0] exp_data,
                            input logic exp_err);
        logic [DATA_W-1:0] rdata;
        logic              err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        check_equal("prdata_o", rdata, exp_data);
        check_equal("pslverr_o", DATA_W'(err), DATA_W'(exp_err));
    endtask

    // --------------------
    // Operation tasks
    // --------------------

    task automatic load_operands(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
        apb_write(ADDR_DIVIDEND, a, 1'b0);
        apb_write(ADDR_DIVISOR, b, 1'b0);
        sh_a = a;
        sh_b = b;
    endtask

    task automatic start_op(input div_op_e op);
        logic [TAG_W-1:0] t;
        t = next_tag;
        model_div(op == OP_DIV, sh_a, sh_b, exp_q[t], exp_r[t]);
        pending[t] = 1'b1;
        issued++;
        next_tag++;
        apb_write(ADDR_CTRL, DATA_W'(op), 1'b0);
    endtask

    task automatic issue(input div_op_e op, input logic [DATA_W-1:0] a,
                         input logic [DATA_W-1:0] b);
        load_operands(a, b);
        start_op(op);
    endtask

    task automatic collect_result();
        logic [TAG_W-1:0] t;
        t = res_tag;
        if (!pending[t]) begin
            $display("Error at %0t: result with tag %0d has no open request", $time, t);
            other_errs++;
        end else begin
            check_equal("res_quotient_o", res_quotient, exp_q[t]);
            check_equal("res_remainder_o", res_remainder, exp_r[t]);
            pending[t] = 1'b0;
        end
        received++;
    endtask

    task automatic wait_drained();
        while (received != issued) @(negedge clk);
        @(posedge clk);
        #2;
    endtask

    // Stream monitor, a transfer completes on the following rising edge
    initial begin
        forever begin
            @(negedge clk);
            if (res_valid && res_ready) begin
                collect_result();
            end
        end
    end

    // --------------------
    // Tests
    // --------------------

    task automatic test_register_map();
        apb_read(ADDR_STATUS, DATA_W'((1 << NUM_LANES) - 1), 1'b0);
        load_operands(32'd100, 32'd7);
        // Unmapped offset must not touch the operands
        apb_write(8'h10, 32'hDEAD_BEEF, 1'b1);
        apb_read(8'h10, '0, 1'b1);
        start_op(OP_DIVU);
        wait_drained();
    endtask

    task automatic test_unsigned();
        logic [DATA_W-1:0] b;
        for (int i = 0; i < 20; i++) begin
            b = $urandom >> ($urandom % 32);
            if (b == '0) begin
                b = 32'd1;
            end
            issue(OP_DIVU, $urandom, b);
        end
        wait_drained();
    endtask

    task automatic test_signed();
        logic [DATA_W-1:0] b;
        issue(OP_DIV, 32'd100, 32'd7);
        issue(OP_DIV, -32'sd100, 32'd7);
        issue(OP_DIV, 32'd100, -32'sd7);
        issue(OP_DIV, -32'sd100, -32'sd7);
        for (int i = 0; i < 10; i++) begin
            b = $urandom >> ($urandom % 32);
            if ($urandom % 2 == 1) begin
                b = -b;
            end
            if (b == '0) begin
                b = 32'd3;
            end
            issue(OP_DIV, $urandom, b);
        end
        wait_drained();
    endtask

    task automatic test_corners();
        div_op_e op;
        for (int m = 0; m < 2; m++) begin
            op = div_op_e'(m);
            issue(op, 32'd1234, 32'd0);
            issue(op, 32'h8000_0000, 32'hFFFF_FFFF);
            issue(op, 32'd12345, 32'd1);
            issue(op, 32'd5, 32'd9);
        end
        wait_drained();
    endtask

    task automatic test_backpressure();
        res_ready = 1'b0;
        for (int i = 0; i <= NUM_LANES; i++) begin
            issue(OP_DIVU, $urandom, ($urandom >> 4) | 32'd1);
        end
        // All lanes busy and the output register full
        apb_read(ADDR_STATUS, DATA_W'(next_tag) << 8, 1'b0);
        fork
            issue(OP_DIV, $urandom, $urandom | 32'd1);
            begin
                wait (psel && penable && paddr == ADDR_CTRL);
                repeat (40) begin
                    @(negedge clk);
                    check_equal("pready_o", DATA_W'(pready), '0);
                end
                @(posedge clk);
                #2;
                res_ready = 1'b1;
            end
        join
        wait_drained();
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin : main
        void'($urandom(27));
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        res_ready = 1'b1;
        arst_n    = 1'b0;
        next_tag  = '0;
        for (int i = 0; i < (1 << TAG_W); i++) begin
            pending[i] = 1'b0;
        end
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        test_register_map();
        test_unsigned();
        test_signed();
        test_corners();
        test_backpressure();
        $display("Errors: %0d mismatches, %0d other", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d of %0d results received",
                 cycles, received, issued);
        $display("Errors: %0d mismatches, %0d other", mismatches, other_errs + 1);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the divide unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module div_unit_tb \
    -f div_unit_top.f \
    -Mdir obj_dir -o div_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/div_unit_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Verification passed$"; then
    exit 0
fi
exit 1
